//--- Bender.yml
package:
  name: vd_output

sources:
  - include_dirs:
      - src
    files:
      - src/vd_pkg.sv
      - src/vip_lane_demux.sv
      - src/pixel_output_stage.sv
      - src/resync_led_stretch.sv
      - src/vd_output_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/vd_output_assert.sv
      - testbench/tb_vd_output.sv

//--- files.f
+incdir+src
src/vd_pkg.sv
src/vip_lane_demux.sv
src/pixel_output_stage.sv
src/resync_led_stretch.sv
src/vd_output_top.sv
testbench/vd_output_assert.sv
testbench/tb_vd_output.sv

//--- src/pixel_output_stage.sv
`timescale 1ns/10ps

`include "vd_defs.svh"

module pixel_output_stage (
    input  logic                   pclk_out,
    input  logic                   sys_reset_n,
    input  logic [`VD_PIXEL_W-1:0] sc_rgb_i,
    input  logic                   sc_hsync_i,
    input  logic                   sc_vsync_i,
    input  logic                   sc_de_i,
    input  logic [`VD_PIXEL_W-1:0] vip_rgb_i,
    input  logic                   vip_select_i,
    input  logic                   osd_enable_i,
    input  vd_pkg::osd_color_e     osd_color_i,
    output logic [`VD_PIXEL_W-1:0] hdmi_tx_d_o,
    output logic                   hdmi_tx_hs_o,
    output logic                   hdmi_tx_vs_o,
    output logic                   hdmi_tx_de_o
);

    // ==================================================
    // Pixel source and OSD overlay
    // ==================================================

    logic [`VD_PIXEL_W-1:0] osd_rgb;
    logic [`VD_PIXEL_W-1:0] src_rgb;
    logic [`VD_PIXEL_W-1:0] next_rgb;

    always_comb begin
        case (osd_color_i)
            vd_pkg::OSD_BLACK: begin
                osd_rgb = `OSD_RGB_BLACK;
            end
            vd_pkg::OSD_BLUE: begin
                osd_rgb = `OSD_RGB_BLUE;
            end
            vd_pkg::OSD_YELLOW: begin
                osd_rgb = `OSD_RGB_YELLOW;
            end
            default: begin
                osd_rgb = `OSD_RGB_WHITE;
            end
        endcase
    end

    // Scan converter unless the VIP path is chosen
    assign src_rgb = vip_select_i ? vip_rgb_i : sc_rgb_i;

    // OSD wins over either source
    assign next_rgb = osd_enable_i ? osd_rgb : src_rgb;

    // ==================================================
    // Rising-edge stage
    // ==================================================

    logic [`VD_PIXEL_W-1:0] stage_rgb;
    logic                   stage_hs;
    logic                   stage_vs;
    logic                   stage_de;

    // Timing always follows the scan converter
    always_ff @(posedge pclk_out or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            stage_rgb <= '0;
            stage_hs  <= 1'b0;
            stage_vs  <= 1'b0;
            stage_de  <= 1'b0;
        end else begin
            stage_rgb <= next_rgb;
            stage_hs  <= sc_hsync_i;
            stage_vs  <= sc_vsync_i;
            stage_de  <= sc_de_i;
        end
    end

    // ==================================================
    // Falling-edge launch
    // ==================================================

    // Half a cycle of setup margin at the transmitter,
    // which samples on the rising edge of pclk_out
    always_ff @(negedge pclk_out or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            hdmi_tx_d_o  <= '0;
            hdmi_tx_hs_o <= 1'b0;
            hdmi_tx_vs_o <= 1'b0;
            hdmi_tx_de_o <= 1'b0;
        end else begin
            hdmi_tx_d_o  <= stage_rgb;
            hdmi_tx_hs_o <= stage_hs;
            hdmi_tx_vs_o <= stage_vs;
            hdmi_tx_de_o <= stage_de;
        end
    end

endmodule

//--- src/resync_led_stretch.sv
`timescale 1ns/10ps

`include "vd_defs.svh"

module resync_led_stretch #(
    parameter int LED_STRETCH_W = `VD_LED_STRETCH_W
) (
    input  logic                  pclk_out,
    input  logic                  sys_reset_n,
    input  logic                  resync_strobe_i,
    output logic [`VD_LEDR_W-1:0] ledr_o
);

    logic                     strobe_sync1;
    logic                     strobe_sync2;
    logic                     strobe_prev;
    logic                     strobe_rise;
    logic [LED_STRETCH_W-1:0] led_ctr;

    // Strobe comes from another clock domain
    always_ff @(posedge pclk_out or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            strobe_sync1 <= 1'b0;
            strobe_sync2 <= 1'b0;
            strobe_prev  <= 1'b0;
        end else begin
            strobe_sync1 <= resync_strobe_i;
            strobe_sync2 <= strobe_sync1;
            strobe_prev  <= strobe_sync2;
        end
    end

    assign strobe_rise = strobe_sync2 & ~strobe_prev;

    // Reload on every new event, else run down to zero
    always_ff @(posedge pclk_out or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            led_ctr <= '0;
        end else if (strobe_rise) begin
            led_ctr <= '1;
        end else if (led_ctr != '0) begin
            led_ctr <= led_ctr - 1'b1;
        end
    end

    assign ledr_o = {`VD_LEDR_W{led_ctr != '0}};

endmodule

//--- src/vd_defs.svh
`ifndef VD_DEFS_SVH
`define VD_DEFS_SVH

// ==================================================
// Pixel format
// ==================================================

// Bits per color component
`define VD_COLOR_W 8

// One RGB pixel, R in the top byte
`define VD_PIXEL_W (3 * `VD_COLOR_W)

// Two pixels per lane pair; lane 1 in the upper half of the bus
`define VD_LANES 2
`define VD_LANE_BUS_W (`VD_LANES * `VD_PIXEL_W)

// ==================================================
// Board outputs
// ==================================================

`define VD_LEDR_W 10
`define VD_LED_STRETCH_W 24

// OSD palette
`define OSD_RGB_BLACK 24'h000000
`define OSD_RGB_BLUE 24'h0000ff
`define OSD_RGB_YELLOW 24'hffff00
`define OSD_RGB_WHITE 24'hffffff

`endif

//--- src/vd_output_top.sv
`timescale 1ns/10ps

`include "vd_defs.svh"

module vd_output_top #(
    parameter int LED_STRETCH_W = `VD_LED_STRETCH_W
) (
    input  logic                      pclk_out,
    input  logic                      sys_reset_n,

    // Video IP output, two pixels per clock
    input  logic [`VD_LANE_BUS_W-1:0] vip_data_i,
    input  logic [`VD_LANES-1:0]      vip_hsync_n_i,
    input  logic [`VD_LANES-1:0]      vip_vsync_n_i,
    input  logic [`VD_LANES-1:0]      vip_de_i,

    // Scan converter output
    input  logic [`VD_PIXEL_W-1:0]    sc_rgb_i,
    input  logic                      sc_hsync_i,
    input  logic                      sc_vsync_i,
    input  logic                      sc_de_i,

    // Control
    input  logic                      vip_select_i,
    input  logic                      osd_enable_i,
    input  vd_pkg::osd_color_e        osd_color_i,
    input  logic                      resync_strobe_i,

    // HDMI transmitter
    output logic [`VD_PIXEL_W-1:0]    hdmi_tx_d_o,
    output logic                      hdmi_tx_hs_o,
    output logic                      hdmi_tx_vs_o,
    output logic                      hdmi_tx_de_o,

    // Status
    output logic                      vip_de_o,
    output logic                      frame_start_o,
    output logic [`VD_LEDR_W-1:0]     ledr_o
);

    logic [`VD_PIXEL_W-1:0] vip_rgb;

    // ==================================================
    // VIP unpack
    // ==================================================

    // Unpacked syncs only feed frame start inside the demux
    vip_lane_demux u_lane_demux (
        .pclk_out      (pclk_out),
        .sys_reset_n   (sys_reset_n),
        .vip_data_i    (vip_data_i),
        .vip_hsync_n_i (vip_hsync_n_i),
        .vip_vsync_n_i (vip_vsync_n_i),
        .vip_de_i      (vip_de_i),
        .pix_rgb_o     (vip_rgb),
        .pix_hsync_o   (),
        .pix_vsync_o   (),
        .pix_de_o      (vip_de_o),
        .frame_start_o (frame_start_o)
    );

    // ==================================================
    // HDMI output
    // ==================================================

    pixel_output_stage u_output_stage (
        .pclk_out     (pclk_out),
        .sys_reset_n  (sys_reset_n),
        .sc_rgb_i     (sc_rgb_i),
        .sc_hsync_i   (sc_hsync_i),
        .sc_vsync_i   (sc_vsync_i),
        .sc_de_i      (sc_de_i),
        .vip_rgb_i    (vip_rgb),
        .vip_select_i (vip_select_i),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .hdmi_tx_d_o  (hdmi_tx_d_o),
        .hdmi_tx_hs_o (hdmi_tx_hs_o),
        .hdmi_tx_vs_o (hdmi_tx_vs_o),
        .hdmi_tx_de_o (hdmi_tx_de_o)
    );

    // ==================================================
    // Resync indicator
    // ==================================================

    resync_led_stretch #(
        .LED_STRETCH_W (LED_STRETCH_W)
    ) u_led_stretch (
        .pclk_out        (pclk_out),
        .sys_reset_n     (sys_reset_n),
        .resync_strobe_i (resync_strobe_i),
        .ledr_o          (ledr_o)
    );

endmodule

//--- src/vd_pkg.sv
package vd_pkg;

    // ==================================================
    // OSD color index
    // ==================================================

    // Index into the four-entry OSD palette
    typedef enum logic [1:0] {
        OSD_BLACK  = 2'd0,
        OSD_BLUE   = 2'd1,
        OSD_YELLOW = 2'd2,
        OSD_WHITE  = 2'd3
    } osd_color_e;

    // ==================================================
    // Lane toggle
    // ==================================================

    // Which half of the two-pixel bus is taken this clock
    typedef enum logic {
        LANE_0 = 1'b0,
        LANE_1 = 1'b1
    } lane_sel_e;

endpackage

//--- src/vip_lane_demux.sv
`timescale 1ns/10ps

`include "vd_defs.svh"

module vip_lane_demux (
    input  logic                      pclk_out,
    input  logic                      sys_reset_n,
    input  logic [`VD_LANE_BUS_W-1:0] vip_data_i,
    input  logic [`VD_LANES-1:0]      vip_hsync_n_i,
    input  logic [`VD_LANES-1:0]      vip_vsync_n_i,
    input  logic [`VD_LANES-1:0]      vip_de_i,
    output logic [`VD_PIXEL_W-1:0]    pix_rgb_o,
    output logic                      pix_hsync_o,
    output logic                      pix_vsync_o,
    output logic                      pix_de_o,
    output logic                      frame_start_o
);

    // ==================================================
    // Lane toggle
    // ==================================================

    vd_pkg::lane_sel_e lane_sel;

    always_ff @(posedge pclk_out or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            lane_sel <= vd_pkg::LANE_0;
        end else if (lane_sel == vd_pkg::LANE_0) begin
            lane_sel <= vd_pkg::LANE_1;
        end else begin
            lane_sel <= vd_pkg::LANE_0;
        end
    end

    // ==================================================
    // Lane select and unpack
    // ==================================================

    logic [`VD_PIXEL_W-1:0] lane_rgb;
    logic                   lane_hsync_n;
    logic                   lane_vsync_n;
    logic                   lane_de;

    always_comb begin
        if (lane_sel == vd_pkg::LANE_1) begin
            lane_rgb     = vip_data_i[`VD_LANE_BUS_W-1:`VD_PIXEL_W];
            lane_hsync_n = vip_hsync_n_i[1];
            lane_vsync_n = vip_vsync_n_i[1];
            lane_de      = vip_de_i[1];
        end else begin
            lane_rgb     = vip_data_i[`VD_PIXEL_W-1:0];
            lane_hsync_n = vip_hsync_n_i[0];
            lane_vsync_n = vip_vsync_n_i[0];
            lane_de      = vip_de_i[0];
        end
    end

    // Syncs leave the video IP active low
    always_ff @(posedge pclk_out or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            pix_rgb_o   <= '0;
            pix_hsync_o <= 1'b0;
            pix_vsync_o <= 1'b0;
            pix_de_o    <= 1'b0;
        end else begin
            pix_rgb_o   <= lane_rgb;
            pix_hsync_o <= ~lane_hsync_n;
            pix_vsync_o <= ~lane_vsync_n;
            pix_de_o    <= lane_de;
        end
    end

    // ==================================================
    // Frame start
    // ==================================================

    logic vsync_prev;
    logic vsync_fall;

    // End of vsync pulse marks the new frame
    assign vsync_fall = vsync_prev & ~pix_vsync_o;

    always_ff @(posedge pclk_out or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            vsync_prev    <= 1'b0;
            frame_start_o <= 1'b0;
        end else begin
            vsync_prev    <= pix_vsync_o;
            frame_start_o <= vsync_fall;
        end
    end

endmodule

//--- testbench/tb_vd_output.sv
`timescale 1ns/10ps

`include "vd_defs.svh"

module tb_vd_output;

    localparam int STRETCH_W = 6;
    localparam int N_ROWS    = 14;
    localparam int EDGE_WAIT = 40;

    logic                      pclk_out;
    logic                      sys_reset_n;
    logic [`VD_LANE_BUS_W-1:0] vip_data_i;
    logic [`VD_LANES-1:0]      vip_hsync_n_i;
    logic [`VD_LANES-1:0]      vip_vsync_n_i;
    logic [`VD_LANES-1:0]      vip_de_i;
    logic [`VD_PIXEL_W-1:0]    sc_rgb_i;
    logic                      sc_hsync_i;
    logic                      sc_vsync_i;
    logic                      sc_de_i;
    logic                      vip_select_i;
    logic                      osd_enable_i;
    vd_pkg::osd_color_e        osd_color_i;
    logic                      resync_strobe_i;
    logic [`VD_PIXEL_W-1:0]    hdmi_tx_d_o;
    logic                      hdmi_tx_hs_o;
    logic                      hdmi_tx_vs_o;
    logic                      hdmi_tx_de_o;
    logic                      vip_de_o;
    logic                      frame_start_o;
    logic [`VD_LEDR_W-1:0]     ledr_o;

    vd_output_top #(
        .LED_STRETCH_W (STRETCH_W)
    ) DUT (
        .pclk_out        (pclk_out),
        .sys_reset_n     (sys_reset_n),
        .vip_data_i      (vip_data_i),
        .vip_hsync_n_i   (vip_hsync_n_i),
        .vip_vsync_n_i   (vip_vsync_n_i),
        .vip_de_i        (vip_de_i),
        .sc_rgb_i        (sc_rgb_i),
        .sc_hsync_i      (sc_hsync_i),
        .sc_vsync_i      (sc_vsync_i),
        .sc_de_i         (sc_de_i),
        .vip_select_i    (vip_select_i),
        .osd_enable_i    (osd_enable_i),
        .osd_color_i     (osd_color_i),
        .resync_strobe_i (resync_strobe_i),
        .hdmi_tx_d_o     (hdmi_tx_d_o),
        .hdmi_tx_hs_o    (hdmi_tx_hs_o),
        .hdmi_tx_vs_o    (hdmi_tx_vs_o),
        .hdmi_tx_de_o    (hdmi_tx_de_o),
        .vip_de_o        (vip_de_o),
        .frame_start_o   (frame_start_o),
        .ledr_o          (ledr_o)
    );

    initial pclk_out = 1'b0;
    always #10 pclk_out = ~pclk_out;

    // ==================================================
    // Stimulus table
    // ==================================================

    // cycles, vip_sel, osd_en, osd_color, strobe, vsync_n, hsync_n, de
    logic [18:0] stim_table [0:N_ROWS-1] = '{
        {8'd8,  1'b0, 1'b0, 2'd0, 1'b0, 2'b11, 2'b11, 2'b11},
        {8'd3,  1'b0, 1'b1, 2'd0, 1'b0, 2'b11, 2'b11, 2'b11},
        {8'd3,  1'b0, 1'b1, 2'd1, 1'b0, 2'b11, 2'b11, 2'b11},
        {8'd3,  1'b1, 1'b1, 2'd2, 1'b0, 2'b11, 2'b11, 2'b11},
        {8'd3,  1'b1, 1'b1, 2'd3, 1'b0, 2'b11, 2'b11, 2'b11},
        {8'd12, 1'b1, 1'b0, 2'd0, 1'b0, 2'b11, 2'b10, 2'b01},
        {8'd4,  1'b1, 1'b0, 2'd0, 1'b0, 2'b00, 2'b11, 2'b11},
        {8'd6,  1'b1, 1'b0, 2'd0, 1'b0, 2'b11, 2'b11, 2'b11},
        {8'd8,  1'b1, 1'b0, 2'd0, 1'b0, 2'b10, 2'b01, 2'b10},
        {8'd6,  1'b0, 1'b0, 2'd0, 1'b0, 2'b11, 2'b11, 2'b11},
        {8'd4,  1'b0, 1'b0, 2'd0, 1'b1, 2'b11, 2'b11, 2'b11},
        {8'd30, 1'b0, 1'b0, 2'd0, 1'b0, 2'b11, 2'b11, 2'b11},
        {8'd3,  1'b0, 1'b0, 2'd0, 1'b1, 2'b11, 2'b11, 2'b11},
        {8'd80, 1'b0, 1'b0, 2'd0, 1'b0, 2'b11, 2'b11, 2'b11}
    };

    // ==================================================
    // Reference model state
    // ==================================================

    logic                    m_lane;
    logic [`VD_PIXEL_W-1:0]  m_pix_rgb;
    logic                    m_pix_vs;
    logic                    m_pix_de;
    logic                    m_vs_prev;
    logic                    m_fs;
    logic [`VD_PIXEL_W-1:0]  m_stage_rgb;
    logic                    m_stage_hs;
    logic                    m_stage_vs;
    logic                    m_stage_de;
    logic                    m_sync1;
    logic                    m_sync2;
    logic                    m_prev;
    logic [STRETCH_W-1:0]    m_ctr;
    logic [31:0]             lfsr_state;
    int                      error_count;
    int                      check_count;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [`VD_PIXEL_W-1:0] osd_constant(input logic [1:0] c);
        case (c)
            2'd0:    return `OSD_RGB_BLACK;
            2'd1:    return `OSD_RGB_BLUE;
            2'd2:    return `OSD_RGB_YELLOW;
            default: return `OSD_RGB_WHITE;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("CHECK FAILED %s expected=%h actual=%h", name, expected, actual);
        end
    endtask

    // Polls in 1 ns steps and returns within 1 ns of the next falling edge
    task automatic wait_falling_edge();
        bit seen_high;
        bit done;
        seen_high = 1'b0;
        done      = 1'b0;
        for (int t = 0; t < EDGE_WAIT && !done; t++) begin
            #1;
            if (pclk_out === 1'b1) begin
                seen_high = 1'b1;
            end else if (seen_high) begin
                done = 1'b1;
            end
        end
        if (!done) begin
            $display("Timeout: no falling clock edge seen within %0d ns", EDGE_WAIT);
            $display("TESTS FAILED");
            $finish;
        end
    endtask

    task automatic check_outputs();
        check_value("hdmi_tx_d_o", 32'(m_stage_rgb), 32'(hdmi_tx_d_o));
        check_value("hdmi_tx_hs_o", 32'(m_stage_hs), 32'(hdmi_tx_hs_o));
        check_value("hdmi_tx_vs_o", 32'(m_stage_vs), 32'(hdmi_tx_vs_o));
        check_value("hdmi_tx_de_o", 32'(m_stage_de), 32'(hdmi_tx_de_o));
        check_value("vip_de_o", 32'(m_pix_de), 32'(vip_de_o));
        check_value("frame_start_o", 32'(m_fs), 32'(frame_start_o));
        check_value("ledr_o", 32'({`VD_LEDR_W{m_ctr != '0}}), 32'(ledr_o));
    endtask

    // Model of the next rising edge from the current state
    task automatic model_rising_edge();
        logic [`VD_PIXEL_W-1:0] lane_rgb;
        logic                   rise;
        lane_rgb = m_lane ? vip_data_i[47:24] : vip_data_i[23:0];
        rise     = m_sync2 & ~m_prev;
        if (osd_enable_i) begin
            m_stage_rgb = osd_constant(osd_color_i);
        end else begin
            m_stage_rgb = vip_select_i ? m_pix_rgb : sc_rgb_i;
        end
        m_stage_hs = sc_hsync_i;
        m_stage_vs = sc_vsync_i;
        m_stage_de = sc_de_i;
        m_fs       = m_vs_prev & ~m_pix_vs;
        m_vs_prev  = m_pix_vs;
        m_pix_rgb  = lane_rgb;
        m_pix_vs   = ~vip_vsync_n_i[m_lane];
        m_pix_de   = vip_de_i[m_lane];
        m_lane     = ~m_lane;
        if (rise) begin
            m_ctr = '1;
        end else if (m_ctr != '0) begin
            m_ctr = m_ctr - 1'b1;
        end
        m_prev  = m_sync2;
        m_sync2 = m_sync1;
        m_sync1 = resync_strobe_i;
    endtask

    task automatic apply_row(input logic [18:0] row);
        logic [63:0] rnd;
        vip_select_i    = row[10];
        osd_enable_i    = row[9];
        osd_color_i     = vd_pkg::osd_color_e'(row[8:7]);
        resync_strobe_i = row[6];
        vip_vsync_n_i   = row[5:4];
        vip_hsync_n_i   = row[3:2];
        vip_de_i        = row[1:0];
        take_bits(48, rnd);
        vip_data_i = rnd[47:0];
        take_bits(27, rnd);
        sc_rgb_i   = rnd[26:3];
        sc_hsync_i = rnd[2];
        sc_vsync_i = rnd[1];
        sc_de_i    = rnd[0];
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        sys_reset_n     = 1'b0;
        vip_data_i      = '0;
        vip_hsync_n_i   = '1;
        vip_vsync_n_i   = '1;
        vip_de_i        = '0;
        sc_rgb_i        = '0;
        sc_hsync_i      = 1'b0;
        sc_vsync_i      = 1'b0;
        sc_de_i         = 1'b0;
        vip_select_i    = 1'b0;
        osd_enable_i    = 1'b0;
        osd_color_i     = vd_pkg::OSD_BLACK;
        resync_strobe_i = 1'b0;
        lfsr_state      = 32'hf8eb_396c;
        error_count     = 0;
        check_count     = 0;
        {m_lane, m_pix_rgb, m_pix_vs, m_pix_de, m_vs_prev, m_fs} = '0;
        {m_stage_rgb, m_stage_hs, m_stage_vs, m_stage_de} = '0;
        {m_sync1, m_sync2, m_prev, m_ctr} = '0;

        // Polls land half a nanosecond away from every clock edge
        #0.5;

        for (int i = 0; i < 5; i++) begin
            wait_falling_edge();
        end
        sys_reset_n = 1'b1;

        // First rising edge out of reset sees the idle inputs
        model_rising_edge();

        for (int r = 0; r < N_ROWS; r++) begin
            for (int c = 0; c < int'(stim_table[r][18:11]); c++) begin
                wait_falling_edge();
                check_outputs();
                apply_row(stim_table[r]);
                model_rising_edge();
            end
        end
        wait_falling_edge();
        check_outputs();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/vd_output_assert.sv
`timescale 1ns/10ps

`include "vd_defs.svh"

module vd_output_assert (
    input logic                  pclk_out,
    input logic                  sys_reset_n,
    input logic                  frame_start_i,
    input logic [`VD_LEDR_W-1:0] ledr_i,
    input vd_pkg::lane_sel_e     lane_sel_i
);

    // Frame start is a single-cycle pulse
    frame_start_single: assert property (
        @(posedge pclk_out) disable iff (!sys_reset_n)
        frame_start_i |=> !frame_start_i
    ) else $error("frame_start_o high on two consecutive cycles");

    // All red LEDs light together
    ledr_uniform: assert property (
        @(posedge pclk_out) disable iff (!sys_reset_n)
        (ledr_i == '0) || (&ledr_i)
    ) else $error("ledr_o bits differ");

    // Lane toggle flips every clock
    lane_alternates: assert property (
        @(posedge pclk_out) disable iff (!sys_reset_n)
        1'b1 |=> (lane_sel_i != $past(lane_sel_i))
    ) else $error("demux lane toggle did not alternate");

endmodule

bind vd_output_top vd_output_assert u_output_assert (
    .pclk_out      (pclk_out),
    .sys_reset_n   (sys_reset_n),
    .frame_start_i (frame_start_o),
    .ledr_i        (ledr_o),
    .lane_sel_i    (u_lane_demux.lane_sel)
);
